// File: hw/alu_pkg.sv
// shared definitions for the execute stage
// opcodes, condition codes, operation classes and flag layout

package alu_pkg;

    // default datapath width
    localparam int DATA_W = 16;

    typedef enum logic [7:0] {
        ADD  = 8'h00,
        SUB  = 8'h01,
        ADC  = 8'h02,
        SBB  = 8'h03,
        CMP  = 8'h04,
        AND  = 8'h05,
        OR   = 8'h06,
        XOR  = 8'h07,
        NOT  = 8'h08,
        NEG  = 8'h09,
        TEST = 8'h0a,
        MOV  = 8'h0b,
        SHL  = 8'h0c,
        SHR  = 8'h0d,
        SAR  = 8'h0e,
        ROL  = 8'h0f,
        JMP  = 8'h10,
        SET  = 8'h11
    } opcode_e;

    // arm style condition codes
    typedef enum logic [3:0] {
        ALWAYS = 4'h0,
        NEVER  = 4'h1,
        EQ     = 4'h2,
        NE     = 4'h3,
        CS     = 4'h4,
        CC     = 4'h5,
        OS     = 4'h6,
        OC     = 4'h7,
        P      = 4'h8,
        N      = 4'h9,
        HI     = 4'ha,
        LS     = 4'hb,
        GE     = 4'hc,
        L      = 4'hd,
        G      = 4'he,
        LE     = 4'hf
    } cond_e;

    // which datapath section produces the result
    typedef enum logic [2:0] {
        ARITH = 3'd0,
        LOGIC = 3'd1,
        SHIFT = 3'd2,
        PASS  = 3'd3,
        COND  = 3'd4,
        NONE  = 3'd7
    } alu_op_e;

    typedef struct packed {
        logic overflow;
        logic sign;
        logic carry;
        logic zero;
    } flags_t;

    // bit positions inside flags_t
    localparam int FLAG_BIT_ZERO     = 0;
    localparam int FLAG_BIT_CARRY    = 1;
    localparam int FLAG_BIT_SIGN     = 2;
    localparam int FLAG_BIT_OVERFLOW = 3;

endpackage

// File: hw/alu_ctrl_if.sv
// decoded control bundle between decoder, datapath and flag unit

`timescale 1ns/10ps

interface alu_ctrl_if import alu_pkg::*; ();

    alu_op_e op_class;
    // second operand enters inverted for overflow
    logic    sub;
    logic    use_carry;
    logic    ov_op;
    logic    write;
    logic    flags_en;
    logic    is_jmp;
    logic    is_set;

    modport decoder (
        output op_class, sub, use_carry, ov_op, write, flags_en, is_jmp, is_set
    );

    modport datapath (
        input op_class, sub, use_carry, ov_op, write, is_jmp, is_set
    );

    modport flags (
        input flags_en
    );

endinterface

// File: hw/op_decoder.sv
// opcode decoder
// combinational map from opcode to operation class and control bits

`timescale 1ns/10ps

module op_decoder import alu_pkg::*; (
    input  opcode_e             opcode,
    alu_ctrl_if.decoder         ctrl
);

    always_comb begin
        ctrl.op_class  = NONE;
        ctrl.sub       = 1'b0;
        ctrl.use_carry = 1'b0;
        ctrl.ov_op     = 1'b0;
        ctrl.write     = 1'b0;
        ctrl.flags_en  = 1'b0;
        ctrl.is_jmp    = 1'b0;
        ctrl.is_set    = 1'b0;

        case (opcode)
            ADD, SUB, ADC, SBB, CMP: begin
                ctrl.op_class = ARITH;
                ctrl.ov_op    = 1'b1;
                ctrl.flags_en = 1'b1;
                // compare only updates flags
                ctrl.write    = (opcode != CMP);
                ctrl.sub      = (opcode == SUB) || (opcode == SBB) || (opcode == CMP);
                ctrl.use_carry = (opcode == ADC) || (opcode == SBB);
            end
            AND, OR, XOR, NOT, NEG: begin
                ctrl.op_class = LOGIC;
                ctrl.write    = 1'b1;
                ctrl.flags_en = 1'b1;
            end
            TEST: begin
                ctrl.op_class = LOGIC;
                ctrl.flags_en = 1'b1;
            end
            MOV: begin
                ctrl.op_class = PASS;
                ctrl.write    = 1'b1;
                ctrl.flags_en = 1'b1;
            end
            SHL, SHR, SAR, ROL: begin
                ctrl.op_class = SHIFT;
                ctrl.write    = 1'b1;
                ctrl.flags_en = 1'b1;
            end
            JMP: begin
                // flags stay as they are across a jump
                ctrl.op_class = COND;
                ctrl.is_jmp   = 1'b1;
            end
            SET: begin
                ctrl.op_class = COND;
                ctrl.is_set   = 1'b1;
                ctrl.write    = 1'b1;
                ctrl.flags_en = 1'b1;
            end
            default: begin
                // unknown opcode, keep the defaults
                ctrl.op_class = NONE;
            end
        endcase
    end

endmodule

// File: hw/shifter.sv
// shift and rotate unit with carry out

`timescale 1ns/10ps

module shifter import alu_pkg::*; #(
    parameter int DATA_W = alu_pkg::DATA_W
) (
    input  opcode_e             opcode,
    input  logic [DATA_W-1:0]   value,
    input  logic [DATA_W-1:0]   amount,
    output logic [DATA_W-1:0]   shifted,
    output logic                carry_out
);

    // low bits of amount used by sar and rol
    localparam int SH_W = $clog2(DATA_W);

    logic [DATA_W:0]     wide;
    logic [2*DATA_W-1:0] rot;

    always_comb begin
        wide      = '0;
        rot       = '0;
        shifted   = '0;
        carry_out = 1'b0;

        case (opcode)
            SHL: begin
                // bit shifted past the top lands in the extra bit
                wide      = {1'b0, value} << amount;
                shifted   = wide[DATA_W-1:0];
                carry_out = wide[DATA_W];
            end
            SHR: begin
                // extra bit below the lsb catches the last bit out
                wide      = {value, 1'b0} >> amount;
                shifted   = wide[DATA_W:1];
                carry_out = wide[0];
            end
            SAR: begin
                shifted = $signed(value) >>> amount[SH_W-1:0];
            end
            ROL: begin
                rot     = {value, value} << amount[SH_W-1:0];
                shifted = rot[2*DATA_W-1:DATA_W];
            end
            default: begin
                shifted = '0;
            end
        endcase
    end

endmodule

// File: hw/arith_logic_unit.sv
// alu datapath
// operand select, arithmetic, logic, next flags and output registers

`timescale 1ns/10ps

module arith_logic_unit import alu_pkg::*; #(
    parameter int DATA_W = alu_pkg::DATA_W
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                op_valid,
    input  opcode_e             opcode,
    input  logic                en_imm,
    input  logic [DATA_W-1:0]   rd_data,
    input  logic [DATA_W-1:0]   rs_data,
    input  logic [DATA_W-1:0]   immediate,
    alu_ctrl_if.datapath        ctrl,
    input  flags_t              flags,
    input  logic                cond_true,
    output logic                result_valid,
    output logic [DATA_W-1:0]   result,
    output logic                write,
    output logic                branch,
    output flags_t              next_flags,
    output logic                flags_load
);

    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] target;
    logic [DATA_W-1:0] logic_val;
    logic [DATA_W-1:0] shifted;
    logic              shift_carry;
    logic              carry_in;
    logic              b_sign;
    // one extra bit on top for carry
    logic [DATA_W:0]   res;

    assign op_a     = rd_data;
    assign op_b     = en_imm ? immediate : rs_data;
    assign target   = en_imm ? immediate : rd_data;
    assign carry_in = ctrl.use_carry & flags.carry;

    shifter #(
        .DATA_W    (DATA_W)
    ) shifter_i (
        .opcode    (opcode),
        .value     (op_a),
        .amount    (op_b),
        .shifted   (shifted),
        .carry_out (shift_carry)
    );

    always_comb begin
        case (opcode)
            AND, TEST: logic_val = op_a & op_b;
            OR:        logic_val = op_a | op_b;
            XOR:       logic_val = op_a ^ op_b;
            NOT:       logic_val = ~op_a;
            NEG:       logic_val = -op_a;
            default:   logic_val = '0;
        endcase
    end

    always_comb begin
        case (ctrl.op_class)
            ARITH: begin
                if (ctrl.sub) begin
                    res = {1'b0, op_a} - {1'b0, op_b} - {{DATA_W{1'b0}}, carry_in};
                end else begin
                    res = {1'b0, op_a} + {1'b0, op_b} + {{DATA_W{1'b0}}, carry_in};
                end
            end
            LOGIC:   res = {1'b0, logic_val};
            SHIFT:   res = {shift_carry, shifted};
            PASS:    res = {1'b0, op_b};
            COND: begin
                // set returns 0 or 1, jmp passes its target
                if (ctrl.is_set) begin
                    res = {{DATA_W{1'b0}}, cond_true};
                end else begin
                    res = {1'b0, target};
                end
            end
            default: res = '0;
        endcase
    end

    // subtraction counts with the second operand sign flipped
    assign b_sign = op_b[DATA_W-1] ^ ctrl.sub;

    always_comb begin
        next_flags.zero     = (res[DATA_W-1:0] == '0);
        next_flags.carry    = res[DATA_W];
        next_flags.sign     = res[DATA_W-1];
        next_flags.overflow = ctrl.ov_op && (op_a[DATA_W-1] == b_sign) &&
                              (op_a[DATA_W-1] != res[DATA_W-1]);
    end

    // flag unit qualifies this with flags_en
    assign flags_load = op_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
            result       <= '0;
            write        <= 1'b0;
            branch       <= 1'b0;
        end else begin
            result_valid <= op_valid;
            write        <= op_valid & ctrl.write;
            branch       <= op_valid & ctrl.is_jmp & cond_true;
            if (op_valid) begin
                result <= res[DATA_W-1:0];
            end
        end
    end

endmodule

// File: hw/flag_unit.sv
// flag register and condition code evaluation

`timescale 1ns/10ps

module flag_unit import alu_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                flags_load,
    input  flags_t              next_flags,
    alu_ctrl_if.flags           flags_en,
    input  cond_e               cond,
    output flags_t              flags,
    output logic                cond_true
);

    logic [3:0] f;

    // loads at the same edge the result is registered
    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (flags_load && flags_en.flags_en) begin
            flags <= next_flags;
        end
    end

    assign f = flags;

    always_comb begin
        case (cond)
            ALWAYS: cond_true = 1'b1;
            NEVER:  cond_true = 1'b0;
            EQ:     cond_true = f[FLAG_BIT_ZERO];
            NE:     cond_true = ~f[FLAG_BIT_ZERO];
            CS:     cond_true = f[FLAG_BIT_CARRY];
            CC:     cond_true = ~f[FLAG_BIT_CARRY];
            OS:     cond_true = f[FLAG_BIT_OVERFLOW];
            OC:     cond_true = ~f[FLAG_BIT_OVERFLOW];
            P:      cond_true = ~f[FLAG_BIT_SIGN];
            N:      cond_true = f[FLAG_BIT_SIGN];
            // carry here means borrow, so higher is carry clear
            HI:     cond_true = ~f[FLAG_BIT_CARRY] & ~f[FLAG_BIT_ZERO];
            LS:     cond_true = f[FLAG_BIT_CARRY] | f[FLAG_BIT_ZERO];
            GE: begin
                cond_true = (f[FLAG_BIT_SIGN] == f[FLAG_BIT_OVERFLOW]);
            end
            L: begin
                cond_true = (f[FLAG_BIT_SIGN] != f[FLAG_BIT_OVERFLOW]);
            end
            G: begin
                cond_true = ~f[FLAG_BIT_ZERO] &
                            (f[FLAG_BIT_SIGN] == f[FLAG_BIT_OVERFLOW]);
            end
            LE: begin
                cond_true = f[FLAG_BIT_ZERO] |
                            (f[FLAG_BIT_SIGN] != f[FLAG_BIT_OVERFLOW]);
            end
            default: cond_true = 1'b0;
        endcase
    end

endmodule

// File: hw/alu_top.sv
// execute stage top level
// decoder, datapath and flag unit joined by the control interface

`timescale 1ns/10ps

module alu_top import alu_pkg::*; #(
    parameter int DATA_W = alu_pkg::DATA_W
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                op_valid,
    input  logic [7:0]          opcode,
    input  logic [3:0]          cond,
    input  logic                en_imm,
    input  logic [DATA_W-1:0]   rd_data,
    input  logic [DATA_W-1:0]   rs_data,
    input  logic [DATA_W-1:0]   immediate,
    output logic                result_valid,
    output logic [DATA_W-1:0]   result,
    output logic                write,
    output logic                branch,
    output logic [3:0]          flags
);

    opcode_e opcode_w;
    cond_e   cond_w;
    flags_t  flags_q;
    flags_t  next_flags;
    logic    flags_load;
    logic    cond_true;

    alu_ctrl_if ctrl_if ();

    assign opcode_w = opcode_e'(opcode);
    assign cond_w   = cond_e'(cond);
    assign flags    = flags_q;

    op_decoder op_decoder_i (
        .opcode       (opcode_w),
        .ctrl         (ctrl_if.decoder)
    );

    arith_logic_unit #(
        .DATA_W       (DATA_W)
    ) arith_logic_unit_i (
        .clk          (clk),
        .rst          (rst),
        .op_valid     (op_valid),
        .opcode       (opcode_w),
        .en_imm       (en_imm),
        .rd_data      (rd_data),
        .rs_data      (rs_data),
        .immediate    (immediate),
        .ctrl         (ctrl_if.datapath),
        .flags        (flags_q),
        .cond_true    (cond_true),
        .result_valid (result_valid),
        .result       (result),
        .write        (write),
        .branch       (branch),
        .next_flags   (next_flags),
        .flags_load   (flags_load)
    );

    flag_unit flag_unit_i (
        .clk          (clk),
        .rst          (rst),
        .flags_load   (flags_load),
        .next_flags   (next_flags),
        .flags_en     (ctrl_if.flags),
        .cond         (cond_w),
        .flags        (flags_q),
        .cond_true    (cond_true)
    );

endmodule

// File: testbench/alu_checker.sv
// concurrent timing checks for the execute stage
// bound into alu_top from the testbench

`timescale 1ns/10ps

module alu_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        op_valid,
    input  logic        result_valid,
    input  logic        write,
    input  logic        branch,
    input  logic [3:0]  flags
);

    // read by the testbench for the closing summary
    int fails = 0;

    // outputs cleared one cycle into reset
    reset_clears: assert property (@(posedge clk)
        rst |=> (!result_valid && !write && !branch && flags == 4'h0))
    else begin
        $error("outputs not cleared while reset is held");
        fails++;
    end

    valid_follows_op: assert property (@(posedge clk) disable iff (rst)
        op_valid |=> result_valid)
    else begin
        $error("result_valid missing one cycle after op_valid");
        fails++;
    end

    // no spurious strobe on idle cycles
    valid_needs_op: assert property (@(posedge clk) disable iff (rst)
        !op_valid |=> !result_valid)
    else begin
        $error("result_valid raised without a preceding op_valid");
        fails++;
    end

    write_needs_valid: assert property (@(posedge clk) disable iff (rst)
        write |-> result_valid)
    else begin
        $error("write asserted without result_valid");
        fails++;
    end

    branch_needs_valid: assert property (@(posedge clk) disable iff (rst)
        branch |-> result_valid)
    else begin
        $error("branch asserted without result_valid");
        fails++;
    end

endmodule

// File: testbench/alu_tb.sv
// testbench for the execute stage
// lfsr stimulus, flag reference model, value checks and summary

`timescale 1ns/10ps

module alu_tb import alu_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int ARITH_N    = 80;
    localparam int LOGIC_N    = 80;
    localparam int UNKNOWN_N  = 12;
    // room for an idle cycle after each op plus reset and margin
    localparam int MAX_CYCLES = 16 + 2 * (ARITH_N + LOGIC_N + UNKNOWN_N) + 3 * 16 * 5 + 200;

    logic        clk;
    logic        rst;
    logic        op_valid;
    logic [7:0]  opcode;
    logic [3:0]  cond;
    logic        en_imm;
    logic [15:0] rd_data;
    logic [15:0] rs_data;
    logic [15:0] immediate;
    logic        result_valid;
    logic [15:0] result;
    logic        write;
    logic        branch;
    logic [3:0]  flags;

    // reference flags as {overflow, sign, carry, zero}
    logic [3:0]  model_flags;
    logic        pend;
    logic [15:0] exp_result;
    logic        exp_write;
    logic        exp_branch;
    logic [31:0] lfsr_state;
    int          errors;

    opcode_e arith_ops [5]  = '{ADD, SUB, ADC, SBB, CMP};
    opcode_e logic_ops [11] = '{AND, OR, XOR, NOT, NEG, TEST, MOV, SHL, SHR, SAR, ROL};
    // setups with known flags for the condition sweep
    opcode_e     setup_op [5] = '{SUB, SUB, ADD, ADD, CMP};
    logic [15:0] setup_a  [5] = '{16'h0005, 16'h0003, 16'h7fff, 16'hffff, 16'h8000};
    logic [15:0] setup_b  [5] = '{16'h0005, 16'h0005, 16'h0001, 16'h0001, 16'h0001};

    alu_top #(
        .DATA_W       (16)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .op_valid     (op_valid),
        .opcode       (opcode),
        .cond         (cond),
        .en_imm       (en_imm),
        .rd_data      (rd_data),
        .rs_data      (rs_data),
        .immediate    (immediate),
        .result_valid (result_valid),
        .result       (result),
        .write        (write),
        .branch       (branch),
        .flags        (flags)
    );

    bind alu_top alu_checker checker_i (
        .clk          (clk),
        .rst          (rst),
        .op_valid     (op_valid),
        .result_valid (result_valid),
        .write        (write),
        .branch       (branch),
        .flags        (flags)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits = {bits[14:0], fb};
        end
        return bits;
    endfunction

    function automatic logic cond_holds(input logic [3:0] c, input logic [3:0] f);
        logic z;
        logic cy;
        logic s;
        logic v;
        z  = f[0];
        cy = f[1];
        s  = f[2];
        v  = f[3];
        case (c)
            ALWAYS:  return 1'b1;
            EQ:      return z;
            NE:      return !z;
            CS:      return cy;
            CC:      return !cy;
            OS:      return v;
            OC:      return !v;
            P:       return !s;
            N:       return s;
            HI:      return !cy && !z;
            LS:      return cy || z;
            GE:      return s == v;
            L:       return s != v;
            G:       return !z && (s == v);
            LE:      return z || (s != v);
            default: return 1'b0;
        endcase
    endfunction

    task automatic predict(input logic [7:0] op, input logic [3:0] c, input logic imm_sel,
                           input logic [15:0] rd, input logic [15:0] rs,
                           input logic [15:0] imm);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] t;
        logic [16:0] wide;
        logic        cin;
        logic        bsign;
        logic        ovf_chk;
        logic        upd;
        logic        ct;
        logic        sc;
        a          = rd;
        b          = imm_sel ? imm : rs;
        cin        = model_flags[1];
        ct         = cond_holds(c, model_flags);
        bsign      = b[15];
        ovf_chk    = 1'b0;
        upd        = 1'b1;
        exp_write  = 1'b1;
        exp_branch = 1'b0;
        case (op)
            ADD:  wide = {1'b0, a} + {1'b0, b};
            ADC:  wide = {1'b0, a} + {1'b0, b} + {16'h0, cin};
            SUB:  wide = {1'b0, a} - {1'b0, b};
            SBB:  wide = {1'b0, a} - {1'b0, b} - {16'h0, cin};
            CMP:  wide = {1'b0, a} - {1'b0, b};
            AND:  wide = {1'b0, a & b};
            TEST: wide = {1'b0, a & b};
            OR:   wide = {1'b0, a | b};
            XOR:  wide = {1'b0, a ^ b};
            NOT:  wide = {1'b0, ~a};
            NEG:  wide = {1'b0, 16'h0 - a};
            MOV:  wide = {1'b0, b};
            SHL:  wide = {1'b0, a} << b;
            SHR: begin
                t = a >> b;
                // carry is the last bit that leaves the bottom
                if (b >= 16'd1 && b <= 16'd16) begin
                    sc = a[int'(b) - 1];
                end else begin
                    sc = 1'b0;
                end
                wide = {sc, t};
            end
            SAR: begin
                t    = $signed(a) >>> b[3:0];
                wide = {1'b0, t};
            end
            ROL: begin
                t    = (a << b[3:0]) | (a >> (16 - int'(b[3:0])));
                wide = {1'b0, t};
            end
            JMP: begin
                wide       = {1'b0, imm_sel ? imm : rd};
                upd        = 1'b0;
                exp_write  = 1'b0;
                exp_branch = ct;
            end
            SET:  wide = {16'h0, ct};
            default: begin
                wide      = '0;
                upd       = 1'b0;
                exp_write = 1'b0;
            end
        endcase
        if (op == ADD || op == ADC || op == SUB || op == SBB || op == CMP) begin
            ovf_chk = 1'b1;
        end
        // subtract-style ops compare against the inverted operand sign
        if (op == SUB || op == SBB || op == CMP) begin
            bsign = ~b[15];
        end
        if (op == CMP || op == TEST) begin
            exp_write = 1'b0;
        end
        exp_result = wide[15:0];
        if (upd) begin
            model_flags[3] = ovf_chk && (a[15] == bsign) && (a[15] != wide[15]);
            model_flags[2] = wide[15];
            model_flags[1] = wide[16];
            model_flags[0] = (wide[15:0] == 16'h0);
        end
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic check_outputs();
        check_value("result_valid", {15'h0, result_valid}, {15'h0, pend});
        check_value("write", {15'h0, write}, {15'h0, exp_write});
        check_value("branch", {15'h0, branch}, {15'h0, exp_branch});
        check_value("flags", {12'h0, flags}, {12'h0, model_flags});
        if (pend) begin
            check_value("result", result, exp_result);
        end
    endtask

    // check the previous cycle, then present the next operation
    task automatic step(input logic valid, input logic [7:0] op, input logic [3:0] c,
                        input logic imm_sel, input logic [15:0] rd, input logic [15:0] rs,
                        input logic [15:0] imm);
        @(negedge clk);
        check_outputs();
        op_valid   = valid;
        opcode     = op;
        cond       = c;
        en_imm     = imm_sel;
        rd_data    = rd;
        rs_data    = rs;
        immediate  = imm;
        pend       = valid;
        exp_write  = 1'b0;
        exp_branch = 1'b0;
        if (valid) begin
            predict(op, c, imm_sel, rd, rs, imm);
        end
    endtask

    task automatic idle();
        step(1'b0, 8'h00, 4'h0, 1'b0, 16'h0, 16'h0, 16'h0);
    endtask

    task automatic random_op(input logic [7:0] op);
        logic        imm_sel;
        logic [3:0]  c;
        logic [15:0] rd;
        logic [15:0] rs;
        logic [15:0] imm;
        imm_sel = (take_bits(1) != 16'h0);
        c       = 4'(take_bits(4));
        rd      = take_bits(16);
        // short shift amounts so carry and data both show up
        if (op == SHL || op == SHR || op == SAR || op == ROL) begin
            rs  = take_bits(5);
            imm = take_bits(5);
        end else begin
            rs  = take_bits(16);
            imm = take_bits(16);
        end
        step(1'b1, op, c, imm_sel, rd, rs, imm);
        if (take_bits(2) == 16'h0) begin
            idle();
        end
    endtask

    initial begin
        logic        imm_sel;
        logic [15:0] rd;
        logic [15:0] imm;
        logic [7:0]  op;
        rst         = 1'b1;
        op_valid    = 1'b0;
        opcode      = 8'h00;
        cond        = 4'h0;
        en_imm      = 1'b0;
        rd_data     = 16'h0;
        rs_data     = 16'h0;
        immediate   = 16'h0;
        lfsr_state  = 32'h5472_3e30;
        model_flags = 4'h0;
        pend        = 1'b0;
        exp_result  = 16'h0;
        exp_write   = 1'b0;
        exp_branch  = 1'b0;
        errors      = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        check_value("result", result, 16'h0);
        rst = 1'b0;

        for (int i = 0; i < ARITH_N; i++) begin
            random_op(arith_ops[int'(take_bits(3)) % 5]);
        end
        for (int i = 0; i < LOGIC_N; i++) begin
            random_op(logic_ops[int'(take_bits(4)) % 11]);
        end

        // jmp leaves flags alone so set sees the same flags
        for (int s = 0; s < 5; s++) begin
            for (int c = 0; c < 16; c++) begin
                step(1'b1, setup_op[s], 4'h0, 1'b0, setup_a[s], setup_b[s], 16'h0);
                imm_sel = (take_bits(1) != 16'h0);
                rd      = take_bits(16);
                imm     = take_bits(16);
                step(1'b1, JMP, 4'(c), imm_sel, rd, 16'h0, imm);
                step(1'b1, SET, 4'(c), 1'b0, 16'h0, 16'h0, 16'h0);
            end
        end

        for (int i = 0; i < UNKNOWN_N; i++) begin
            step(1'b1, SUB, 4'h0, 1'b0, 16'h0003, 16'h0005, 16'h0);
            op = 8'(18 + int'(take_bits(8)) % 238);
            step(1'b1, op, 4'(take_bits(4)), 1'b0, take_bits(16), take_bits(16), 16'h0);
        end
        idle();
        idle();

        $display("errors: %0d value checks, %0d timing assertions",
                 errors, dut_i.checker_i.fails);
        if (errors == 0 && dut_i.checker_i.fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("timeout: test sequence did not finish within %0d cycles", MAX_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: compile.f
hw/alu_pkg.sv
hw/alu_ctrl_if.sv
hw/op_decoder.sv
hw/shifter.sv
hw/arith_logic_unit.sv
hw/flag_unit.sv
hw/alu_top.sv
testbench/alu_checker.sv
testbench/alu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the execute stage testbench with verilator and run it

verilator --binary --timing --assert -Wno-fatal --top-module alu_tb -f compile.f -o alu_sim \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/alu_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "Result: FAILED" sim.log && { echo "simulation failed"; exit 1; } \
    || { echo "simulation finished without failures"; exit 0; }
